// File: rtl/loc_macros.svh
`ifndef LOC_MACROS_SVH
`define LOC_MACROS_SVH

// array geometry, 0.1 mm units
`define LOC_MIC_SPACING 200

// sound speed in 0.1 mm per 0.1 ms
`define LOC_SOUND_VEL   340
`define LOC_SAMPLE_FREQ 93750

// solver divisors
`define LOC_COEF1       (8 * 1732 * `LOC_MIC_SPACING / 100)
`define LOC_COEF2       (160 * `LOC_MIC_SPACING)

// camera intrinsics
`define LOC_FX          437
`define LOC_CX          242
`define LOC_FY          330
`define LOC_CY          145

`define LOC_DATA_W      32

`endif

// File: rtl/loc_pkg.sv
`include "loc_macros.svh"

package loc_pkg;

    typedef logic [5:0] lag_t;                           // sample periods, signed
    typedef logic signed [`LOC_DATA_W-1:0] dist_t;       // 0.1 mm
    typedef logic signed [`LOC_DATA_W-1:0] pos_t;
    typedef logic [15:0] depth_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD_DIST,
        WAIT_DIST,
        LOAD_R,
        WAIT_R,
        LOAD_X,
        WAIT_X,
        LOAD_Y,
        WAIT_Y,
        RUN_SQRT,
        LOAD_U,
        WAIT_U,
        LOAD_V,
        WAIT_V,
        FINISH
    } solver_state_e;

endpackage

// File: rtl/apb_pkg.sv
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_STATUS = 8'h04,
        REG_LAG_LO = 8'h08,
        REG_LAG_HI = 8'h0C,
        REG_POS_X  = 8'h10,
        REG_POS_Y  = 8'h14,
        REG_POS_Z  = 8'h18,
        REG_IMG_X  = 8'h1C,
        REG_IMG_Y  = 8'h20
    } reg_offset_e;

endpackage

// File: rtl/arith_if.sv
`timescale 1ns/10ps
`include "loc_macros.svh"

interface div_if #(parameter int WIDTH = `LOC_DATA_W);
    logic                    start;       // one cycle, operands held until done
    logic signed [WIDTH-1:0] dividend;
    logic signed [WIDTH-1:0] divisor;
    logic signed [WIDTH-1:0] quotient;
    logic                    div_zero;
    logic                    done;

    modport client (output start, dividend, divisor, input quotient, div_zero, done);
    modport engine (input start, dividend, divisor, output quotient, div_zero, done);
endinterface

interface sqrt_if #(parameter int ROOT_W = 16);
    logic                  start;
    logic [2*ROOT_W-1:0]   radicand;
    logic [ROOT_W-1:0]     root;
    logic                  done;

    modport client (output start, radicand, input root, done);
    modport engine (input start, radicand, output root, done);
endinterface

// File: rtl/seq_divider.sv
`timescale 1ns/10ps
`include "loc_macros.svh"

module seq_divider #(
    parameter int WIDTH = `LOC_DATA_W
) (
    input  logic   clk,
    input  logic   rst_n,
    div_if.engine  dv
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [WIDTH-1:0] num_q;        // dividend magnitude, quotient shifts in
    logic [WIDTH-1:0] dvs_q;
    logic [WIDTH-1:0] rem_q;
    logic             neg_q;
    logic             zero_q;
    logic             run_q;
    logic [CNT_W-1:0] cnt_q;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   trial;

    assign shifted = {rem_q, num_q[WIDTH-1]};
    assign trial   = shifted - {1'b0, dvs_q};   // msb set means it does not fit

    always_ff @(posedge clk) begin
        if (dv.start) begin
            num_q  <= dv.dividend[WIDTH-1] ? -dv.dividend : dv.dividend;
            dvs_q  <= dv.divisor[WIDTH-1] ? -dv.divisor : dv.divisor;
            rem_q  <= '0;
            neg_q  <= dv.dividend[WIDTH-1] ^ dv.divisor[WIDTH-1];
            zero_q <= (dv.divisor == '0);
        end else if (run_q && cnt_q != '0) begin
            rem_q <= trial[WIDTH] ? shifted[WIDTH-1:0] : trial[WIDTH-1:0];
            num_q <= {num_q[WIDTH-2:0], ~trial[WIDTH]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q       <= 1'b0;
            cnt_q       <= '0;
            dv.done     <= 1'b0;
            dv.div_zero <= 1'b0;
            dv.quotient <= '0;
        end else begin
            dv.done <= 1'b0;
            if (dv.start) begin
                run_q <= 1'b1;
                cnt_q <= CNT_W'(WIDTH);
            end else if (run_q) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    run_q       <= 1'b0;
                    dv.done     <= 1'b1;
                    dv.div_zero <= zero_q;
                    dv.quotient <= zero_q ? '0 : (neg_q ? -num_q : num_q);  // toward zero
                end
            end
        end
    end

endmodule

// File: rtl/int_sqrt.sv
`timescale 1ns/10ps

module int_sqrt #(
    parameter int ROOT_W = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    sqrt_if.engine  sq
);

    localparam int CNT_W = $clog2(ROOT_W + 1);

    logic [2*ROOT_W-1:0] rad_q;
    logic [ROOT_W+1:0]   rem_q;
    logic [ROOT_W-1:0]   root_q;
    logic [ROOT_W+1:0]   rem_sh;
    logic [ROOT_W+1:0]   trial;
    logic                fit;
    logic                run_q;
    logic [CNT_W-1:0]    cnt_q;

    assign rem_sh = {rem_q[ROOT_W-1:0], rad_q[2*ROOT_W-1 -: 2]};  // bring down two bits
    assign trial  = {root_q, 2'b01};                               // 4*root + 1
    assign fit    = (rem_sh >= trial);

    always_ff @(posedge clk) begin
        if (sq.start) begin
            rad_q  <= sq.radicand;
            rem_q  <= '0;
            root_q <= '0;
        end else if (run_q && cnt_q != '0) begin
            rad_q  <= rad_q << 2;
            rem_q  <= fit ? rem_sh - trial : rem_sh;
            root_q <= {root_q[ROOT_W-2:0], fit};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            cnt_q   <= '0;
            sq.done <= 1'b0;
            sq.root <= '0;
        end else begin
            sq.done <= 1'b0;
            if (sq.start) begin
                run_q <= 1'b1;
                cnt_q <= CNT_W'(ROOT_W);
            end else if (run_q) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    run_q   <= 1'b0;
                    sq.done <= 1'b1;
                    sq.root <= root_q;
                end
            end
        end
    end

endmodule

// File: rtl/cal_position.sv
`timescale 1ns/10ps
`include "loc_macros.svh"

module cal_position (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go,
    input  loc_pkg::lag_t    lag [6],
    output logic             busy,
    output logic             fin,
    output logic             div_zero,
    output loc_pkg::pos_t    x,
    output loc_pkg::pos_t    y,
    output loc_pkg::depth_t  z,
    output loc_pkg::pos_t    x_2d,
    output loc_pkg::pos_t    y_2d,
    div_if.client            dv,
    sqrt_if.client           sq
);

    loc_pkg::solver_state_e state_q;
    logic [2:0]             idx_q;          // distance being converted
    logic                   sq_start_q;
    logic                   load_go;
    loc_pkg::lag_t          lag_q [6];
    loc_pkg::dist_t         dist_q [6];
    loc_pkg::dist_t         dsq [6];
    loc_pkg::dist_t         r_q;
    loc_pkg::dist_t         lag_ext;
    loc_pkg::dist_t         sum_x;
    loc_pkg::dist_t         sum_y;
    loc_pkg::dist_t         r_div10;
    loc_pkg::dist_t         rad_s;
    loc_pkg::dist_t         z_ext;

    assign load_go = go && (state_q inside {loc_pkg::IDLE, loc_pkg::FINISH});
    assign busy    = !(state_q inside {loc_pkg::IDLE, loc_pkg::FINISH});
    assign fin     = (state_q == loc_pkg::FINISH);

    assign lag_ext = loc_pkg::dist_t'(signed'(lag_q[idx_q]));
    assign z_ext   = loc_pkg::dist_t'(z);                      // zero extend
    assign sum_x   = dist_q[2] - dist_q[0] + dist_q[3] - dist_q[5];
    assign sum_y   = dist_q[4] - dist_q[1] + dist_q[5] - dist_q[0] + dist_q[3] - dist_q[2];
    assign r_div10 = r_q / 10;
    assign rad_s   = r_div10 * r_div10 - x * x - y * y;

    assign dv.start    = state_q inside {loc_pkg::LOAD_DIST, loc_pkg::LOAD_R, loc_pkg::LOAD_X,
                                         loc_pkg::LOAD_Y, loc_pkg::LOAD_U, loc_pkg::LOAD_V};
    assign sq.start    = sq_start_q;
    assign sq.radicand = (rad_s < 0) ? '0 : rad_s;             // behind the array, clamp

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            dsq[i] = dist_q[i] * dist_q[i];
        end
    end

    // operands stay valid through the wait state
    always_comb begin
        dv.dividend = '0;
        dv.divisor  = '0;
        case (state_q)
            loc_pkg::LOAD_DIST, loc_pkg::WAIT_DIST: begin
                dv.dividend = lag_ext * `LOC_SOUND_VEL * 10000;
                dv.divisor  = `LOC_SAMPLE_FREQ;
            end
            loc_pkg::LOAD_R, loc_pkg::WAIT_R: begin
                dv.dividend = dsq[5] - dsq[3] + dsq[2] - dsq[0];
                dv.divisor  = 2 * (dist_q[0] - dist_q[2] + dist_q[3] - dist_q[5]);
            end
            loc_pkg::LOAD_X, loc_pkg::WAIT_X: begin
                dv.dividend = 2 * r_q * sum_x + dsq[2] - dsq[0] + dsq[3] - dsq[5];
                dv.divisor  = `LOC_COEF1;
            end
            loc_pkg::LOAD_Y, loc_pkg::WAIT_Y: begin
                dv.dividend = 2 * r_q * sum_y + dsq[4] - dsq[1] + dsq[5] - dsq[0]
                              + dsq[3] - dsq[2];
                dv.divisor  = `LOC_COEF2;
            end
            loc_pkg::LOAD_U, loc_pkg::WAIT_U: begin
                dv.dividend = `LOC_FX * x + `LOC_CX * z_ext;
                dv.divisor  = z_ext;
            end
            loc_pkg::LOAD_V, loc_pkg::WAIT_V: begin
                dv.dividend = `LOC_FY * y + `LOC_CY * z_ext;
                dv.divisor  = z_ext;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_go) begin
            lag_q <= lag;
        end
        if (state_q == loc_pkg::WAIT_DIST && dv.done) begin
            dist_q[idx_q] <= dv.quotient;
        end
        if (state_q == loc_pkg::WAIT_R && dv.done) begin
            r_q <= dv.quotient;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= loc_pkg::IDLE;
            idx_q      <= '0;
            sq_start_q <= 1'b0;
            div_zero   <= 1'b0;
            x          <= '0;
            y          <= '0;
            z          <= '0;
            x_2d       <= '0;
            y_2d       <= '0;
        end else begin
            sq_start_q <= 1'b0;
            if (dv.done) begin
                div_zero <= div_zero | dv.div_zero;   // sticky over the solve
            end
            case (state_q)
                loc_pkg::IDLE, loc_pkg::FINISH: begin
                    if (load_go) begin
                        state_q  <= loc_pkg::LOAD_DIST;
                        idx_q    <= '0;
                        div_zero <= 1'b0;
                    end else begin
                        state_q <= loc_pkg::IDLE;
                    end
                end
                loc_pkg::LOAD_DIST: state_q <= loc_pkg::WAIT_DIST;
                loc_pkg::WAIT_DIST: begin
                    if (dv.done) begin
                        if (idx_q == 3'd5) begin
                            state_q <= loc_pkg::LOAD_R;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= loc_pkg::LOAD_DIST;
                        end
                    end
                end
                loc_pkg::LOAD_R: state_q <= loc_pkg::WAIT_R;
                loc_pkg::WAIT_R: begin
                    if (dv.done) begin
                        state_q <= loc_pkg::LOAD_X;
                    end
                end
                loc_pkg::LOAD_X: state_q <= loc_pkg::WAIT_X;
                loc_pkg::WAIT_X: begin
                    if (dv.done) begin
                        x       <= dv.quotient;
                        state_q <= loc_pkg::LOAD_Y;
                    end
                end
                loc_pkg::LOAD_Y: state_q <= loc_pkg::WAIT_Y;
                loc_pkg::WAIT_Y: begin
                    if (dv.done) begin
                        y          <= dv.quotient;
                        sq_start_q <= 1'b1;
                        state_q    <= loc_pkg::RUN_SQRT;
                    end
                end
                loc_pkg::RUN_SQRT: begin
                    if (sq.done) begin
                        z       <= sq.root;
                        state_q <= loc_pkg::LOAD_U;
                    end
                end
                loc_pkg::LOAD_U: state_q <= loc_pkg::WAIT_U;
                loc_pkg::WAIT_U: begin
                    if (dv.done) begin
                        x_2d    <= dv.quotient;
                        state_q <= loc_pkg::LOAD_V;
                    end
                end
                loc_pkg::LOAD_V: state_q <= loc_pkg::WAIT_V;
                loc_pkg::WAIT_V: begin
                    if (dv.done) begin
                        y_2d    <= dv.quotient;
                        state_q <= loc_pkg::FINISH;
                    end
                end
                default: state_q <= loc_pkg::IDLE;
            endcase
        end
    end

endmodule

// File: rtl/loc_apb_regs.sv
`timescale 1ns/10ps

module loc_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_pkg::apb_addr_t  paddr,
    input  apb_pkg::apb_data_t  pwdata,
    output apb_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                go,
    output loc_pkg::lag_t       lag [6],
    input  logic                busy,
    input  logic                fin,
    input  logic                div_zero,
    input  loc_pkg::pos_t       x,
    input  loc_pkg::pos_t       y,
    input  loc_pkg::depth_t     z,
    input  loc_pkg::pos_t       x_2d,
    input  loc_pkg::pos_t       y_2d,
    output logic                irq
);

    logic access;
    logic mapped;
    logic read_only;
    logic is_ctrl;
    logic wr_ok;
    logic done_q;

    assign access  = psel && penable;
    assign is_ctrl = (paddr == apb_pkg::REG_CTRL);
    assign pslverr = access && (!mapped || (pwrite && read_only)
                                || (pwrite && is_ctrl && pwdata[0] && busy));
    assign wr_ok   = access && pwrite && !pslverr;
    assign go      = wr_ok && is_ctrl && pwdata[0];
    assign pready  = 1'b1;                       // no wait states
    assign irq     = done_q;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b1;
        prdata    = '0;
        case (apb_pkg::reg_offset_e'(paddr))
            apb_pkg::REG_CTRL:   read_only = 1'b0;
            apb_pkg::REG_STATUS: prdata = {29'd0, div_zero, done_q, busy};
            apb_pkg::REG_LAG_LO: begin
                read_only = 1'b0;
                prdata    = {2'b00, lag[3], 2'b00, lag[2], 2'b00, lag[1], 2'b00, lag[0]};
            end
            apb_pkg::REG_LAG_HI: begin
                read_only = 1'b0;
                prdata    = {16'd0, 2'b00, lag[5], 2'b00, lag[4]};
            end
            apb_pkg::REG_POS_X:  prdata = x;
            apb_pkg::REG_POS_Y:  prdata = y;
            apb_pkg::REG_POS_Z:  prdata = {16'd0, z};
            apb_pkg::REG_IMG_X:  prdata = x_2d;
            apb_pkg::REG_IMG_Y:  prdata = y_2d;
            default:             mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            for (int i = 0; i < 6; i++) begin
                lag[i] <= '0;
            end
        end else begin
            if (go) begin
                done_q <= 1'b0;                  // new solve clears done
            end else if (fin) begin
                done_q <= 1'b1;
            end
            if (wr_ok && paddr == apb_pkg::REG_LAG_LO) begin
                lag[0] <= pwdata[5:0];
                lag[1] <= pwdata[13:8];
                lag[2] <= pwdata[21:16];
                lag[3] <= pwdata[29:24];
            end
            if (wr_ok && paddr == apb_pkg::REG_LAG_HI) begin
                lag[4] <= pwdata[5:0];
                lag[5] <= pwdata[13:8];
            end
        end
    end

endmodule

// File: rtl/sound_locator_top.sv
`timescale 1ns/10ps
`include "loc_macros.svh"

module sound_locator_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_pkg::apb_addr_t  paddr,
    input  apb_pkg::apb_data_t  pwdata,
    output apb_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                irq
);

    logic            go;
    logic            busy;
    logic            fin;
    logic            div_zero;
    loc_pkg::lag_t   lag [6];
    loc_pkg::pos_t   x;
    loc_pkg::pos_t   y;
    loc_pkg::depth_t z;
    loc_pkg::pos_t   x_2d;
    loc_pkg::pos_t   y_2d;

    div_if  #(.WIDTH(`LOC_DATA_W))              div_bus ();
    sqrt_if #(.ROOT_W($bits(loc_pkg::depth_t))) sqrt_bus ();

    loc_apb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .go(go), .lag(lag), .busy(busy), .fin(fin), .div_zero(div_zero),
        .x(x), .y(y), .z(z), .x_2d(x_2d), .y_2d(y_2d), .irq(irq)
    );

    cal_position u_solver (
        .clk(clk), .rst_n(rst_n), .go(go), .lag(lag),
        .busy(busy), .fin(fin), .div_zero(div_zero),
        .x(x), .y(y), .z(z), .x_2d(x_2d), .y_2d(y_2d),
        .dv(div_bus.client), .sq(sqrt_bus.client)
    );

    seq_divider #(.WIDTH(`LOC_DATA_W)) u_div (
        .clk(clk), .rst_n(rst_n), .dv(div_bus.engine)
    );

    int_sqrt #(.ROOT_W($bits(loc_pkg::depth_t))) u_sqrt (
        .clk(clk), .rst_n(rst_n), .sq(sqrt_bus.engine)
    );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;                         // release off the edge
    end

endmodule

// File: sim/tb_sound_locator.sv
`timescale 1ns/10ps
`include "loc_macros.svh"

module tb_sound_locator;

    localparam int          MAX_CYCLES = 20000;          // 11 solves of < 500 cycles plus polling
    localparam logic [31:0] LFSR_SEED  = 32'h579ec491;
    localparam logic [31:0] LFSR_TAPS  = 32'hA300_0000;

    logic               clk;
    logic               rst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_pkg::apb_addr_t paddr;
    apb_pkg::apb_data_t pwdata;
    apb_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;
    logic               irq;
    int                 cycle_cnt = 0;
    logic [31:0]        lfsr_state;
    loc_pkg::lag_t      cur_lag [6];
    loc_pkg::pos_t      exp_x;
    loc_pkg::pos_t      exp_y;
    loc_pkg::depth_t    exp_z;
    loc_pkg::pos_t      exp_u;
    loc_pkg::pos_t      exp_v;
    logic               exp_zero;

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

    sound_locator_top UUT (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the solve or the bus did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_pos(input string what, input loc_pkg::pos_t got, input loc_pkg::pos_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_depth(input string what, input loc_pkg::depth_t got,
                               input loc_pkg::depth_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input apb_pkg::apb_data_t got,
                              input apb_pkg::apb_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // SETUP then ACCESS, response taken mid-cycle
    task automatic apb_transfer(input logic wr, input apb_pkg::apb_addr_t addr,
                                input apb_pkg::apb_data_t wdata,
                                output apb_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_flag("pready in ACCESS", pready, 1'b1);
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                             output logic err);
        apb_pkg::apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int lag_value(input loc_pkg::lag_t l);
        return l[5] ? int'(l) - 64 : int'(l);
    endfunction

    function automatic int trunc_div(input int a, input int b);
        longint q;
        if (b == 0) begin
            return 0;                          // zero divisor yields zero
        end
        q = longint'(a) / longint'(b);
        return int'(q);
    endfunction

    function automatic int floor_sqrt(input int v);
        int r;
        int t;
        r = 0;
        for (int b = 15; b >= 0; b--) begin
            t = r | (1 << b);
            if (longint'(t) * longint'(t) <= longint'(v)) begin
                r = t;
            end
        end
        return r;
    endfunction

    // solver rules in 32-bit wrapping arithmetic
    function automatic void compute_expected();
        int d [6];
        int s [6];
        int den;
        int r;
        int xv;
        int yv;
        int r10;
        int rad;
        int zv;
        for (int i = 0; i < 6; i++) begin
            d[i] = trunc_div(lag_value(cur_lag[i]) * `LOC_SOUND_VEL * 10000, `LOC_SAMPLE_FREQ);
            s[i] = d[i] * d[i];
        end
        den = 2 * (d[0] - d[2] + d[3] - d[5]);
        r   = trunc_div(s[5] - s[3] + s[2] - s[0], den);
        xv  = trunc_div(2 * r * (d[2] - d[0] + d[3] - d[5]) + s[2] - s[0] + s[3] - s[5],
                        `LOC_COEF1);
        yv  = trunc_div(2 * r * (d[4] - d[1] + d[5] - d[0] + d[3] - d[2])
                        + s[4] - s[1] + s[5] - s[0] + s[3] - s[2], `LOC_COEF2);
        r10 = r / 10;
        rad = r10 * r10 - xv * xv - yv * yv;
        if (rad < 0) begin
            rad = 0;
        end
        zv       = floor_sqrt(rad);
        exp_x    = xv;
        exp_y    = yv;
        exp_z    = loc_pkg::depth_t'(zv);
        exp_u    = trunc_div(`LOC_FX * xv + `LOC_CX * zv, zv);
        exp_v    = trunc_div(`LOC_FY * yv + `LOC_CY * zv, zv);
        exp_zero = (den == 0) || (zv == 0);
    endfunction

    task automatic start_solve();
        apb_pkg::apb_data_t rd;
        logic               err;
        apb_write(apb_pkg::REG_LAG_LO, {2'b00, cur_lag[3], 2'b00, cur_lag[2],
                                        2'b00, cur_lag[1], 2'b00, cur_lag[0]}, err);
        apb_write(apb_pkg::REG_LAG_HI, {18'd0, cur_lag[5], 2'b00, cur_lag[4]}, err);
        compute_expected();
        apb_write(apb_pkg::REG_CTRL, 32'h1, err);
        check_flag("pslverr on start", err, 1'b0);
        apb_read(apb_pkg::REG_STATUS, rd, err);
        check_flag("STATUS.busy after start", rd[0], 1'b1);
        check_flag("STATUS.done after start", rd[1], 1'b0);
    endtask

    task automatic wait_idle();
        apb_pkg::apb_data_t rd;
        logic               err;
        do begin
            apb_read(apb_pkg::REG_STATUS, rd, err);
        end while (rd[0]);
    endtask

    task automatic check_results();
        apb_pkg::apb_data_t rd;
        logic               err;
        apb_read(apb_pkg::REG_STATUS, rd, err);
        check_flag("STATUS.busy", rd[0], 1'b0);
        check_flag("STATUS.done", rd[1], 1'b1);
        check_flag("STATUS.div_zero", rd[2], exp_zero);
        check_flag("irq", irq, 1'b1);
        apb_read(apb_pkg::REG_POS_X, rd, err);
        check_pos("x", rd, exp_x);
        apb_read(apb_pkg::REG_POS_Y, rd, err);
        check_pos("y", rd, exp_y);
        apb_read(apb_pkg::REG_POS_Z, rd, err);
        check_depth("z", rd[15:0], exp_z);
        check_flag("z upper bits", |rd[31:16], 1'b0);
        apb_read(apb_pkg::REG_IMG_X, rd, err);
        check_pos("x_2d", rd, exp_u);
        apb_read(apb_pkg::REG_IMG_Y, rd, err);
        check_pos("y_2d", rd, exp_v);
    endtask

    task automatic test_reset_values();
        apb_pkg::apb_data_t rd;
        logic               err;
        apb_read(apb_pkg::REG_STATUS, rd, err);
        check_word("STATUS after reset", rd, 32'h0);
        check_flag("irq after reset", irq, 1'b0);
        apb_read(apb_pkg::REG_POS_X, rd, err);
        check_pos("x after reset", rd, 0);
        apb_read(apb_pkg::REG_POS_Y, rd, err);
        check_pos("y after reset", rd, 0);
        apb_read(apb_pkg::REG_POS_Z, rd, err);
        check_depth("z after reset", rd[15:0], 16'd0);
        apb_read(apb_pkg::REG_IMG_X, rd, err);
        check_pos("x_2d after reset", rd, 0);
        apb_read(apb_pkg::REG_IMG_Y, rd, err);
        check_pos("y_2d after reset", rd, 0);
    endtask

    task automatic test_register_access();
        apb_pkg::apb_data_t rd;
        logic               err;
        apb_write(apb_pkg::REG_LAG_LO, 32'hC5AA_7F15, err);
        check_flag("pslverr on LAG_LO write", err, 1'b0);
        apb_write(apb_pkg::REG_LAG_HI, 32'hFFFF_E123, err);
        check_flag("pslverr on LAG_HI write", err, 1'b0);
        apb_write(8'h24, 32'h0, err);
        check_flag("pslverr on unmapped write", err, 1'b1);
        apb_write(apb_pkg::REG_POS_X, 32'h0000_1235, err);
        check_flag("pslverr on POS_X write", err, 1'b1);
        apb_read(8'h30, rd, err);
        check_flag("pslverr on unmapped read", err, 1'b1);
        apb_read(apb_pkg::REG_LAG_LO, rd, err);
        check_word("LAG_LO", rd, 32'hC5AA_7F15 & 32'h3F3F_3F3F);
        apb_read(apb_pkg::REG_LAG_HI, rd, err);
        check_word("LAG_HI", rd, 32'hFFFF_E123 & 32'h0000_3F3F);
        apb_read(apb_pkg::REG_STATUS, rd, err);
        check_word("STATUS after rejected writes", rd, 32'h0);   // no solve started
    endtask

    task automatic test_fixed_vector();
        cur_lag = '{6'h03, 6'h3B, 6'h07, 6'h3E, 6'h04, 6'h01};
        start_solve();
        wait_idle();
        check_results();
    endtask

    task automatic test_random_vectors();
        for (int n = 0; n < 8; n++) begin
            for (int i = 0; i < 6; i++) begin
                cur_lag[i] = random_bits(6);
            end
            start_solve();
            wait_idle();
            check_results();
        end
    endtask

    task automatic test_zero_lags();
        apb_pkg::apb_data_t rd;
        logic               err;
        cur_lag = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00};
        start_solve();
        wait_idle();
        apb_read(apb_pkg::REG_STATUS, rd, err);
        check_flag("STATUS.div_zero for zero lags", rd[2], 1'b1);
        check_results();
    endtask

    task automatic test_start_while_busy();
        logic err;
        cur_lag = '{6'h3C, 6'h02, 6'h39, 6'h05, 6'h3F, 6'h06};
        start_solve();
        apb_write(apb_pkg::REG_CTRL, 32'h1, err);
        check_flag("pslverr on start while busy", err, 1'b1);
        apb_write(apb_pkg::REG_LAG_LO, 32'h0101_0101, err);   // running solve keeps its lags
        wait_idle();
        check_results();
    endtask

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = LFSR_SEED;
        @(posedge rst_n);
        repeat (2) @(posedge clk);
        test_reset_values();
        test_register_access();
        test_fixed_vector();
        test_random_vectors();
        test_zero_lags();
        test_start_while_busy();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/loc_pkg.sv
rtl/apb_pkg.sv
rtl/arith_if.sv
rtl/seq_divider.sv
rtl/int_sqrt.sv
rtl/cal_position.sv
rtl/loc_apb_regs.sv
rtl/sound_locator_top.sv
sim/tb_clk_gen.sv
sim/tb_sound_locator.sv

// File: Bender.yml
package:
  name: sound_locator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/loc_pkg.sv
      - rtl/apb_pkg.sv
      - rtl/arith_if.sv
      - rtl/seq_divider.sv
      - rtl/int_sqrt.sv
      - rtl/cal_position.sv
      - rtl/loc_apb_regs.sv
      - rtl/sound_locator_top.sv
      - target: simulation
        files:
          - sim/tb_clk_gen.sv
          - sim/tb_sound_locator.sv
